//--- verilog/ram_arb_pkg.sv
package ram_arb_pkg;

  // data and address widths
  localparam int XLEN   = 64;
  localparam int ADDR_W = 32;
  localparam int MASK_W = 8;   // one bit per byte lane

  // word ram, index is addr[10:3]
  localparam int RAM_WORDS = 256;
  localparam int IDX_W     = 8;

  // state encodings, same for both engines
  localparam int ST_W = 3;
  localparam logic [ST_W-1:0] ST_IDLE    = 3'd0;
  localparam logic [ST_W-1:0] ST_MEM1    = 3'd1;
  localparam logic [ST_W-1:0] ST_MEM2    = 3'd2;
  localparam logic [ST_W-1:0] ST_PREIDLE = 3'd4;  // one cycle after reset

  // one ram word, seen whole or as byte lanes
  typedef union packed {
    logic [XLEN-1:0]        raw;
    logic [MASK_W-1:0][7:0] lanes;  // lane i = bits 8i+7:8i
  } ram_word_u;

endpackage

//--- verilog/mem_write_fsm.sv
module mem_write_fsm (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             wr_valid_i,
  input  logic [ram_arb_pkg::ADDR_W-1:0]   wr_addr_i,
  input  logic [ram_arb_pkg::MASK_W-1:0]   wr_mask_i,
  input  logic [ram_arb_pkg::XLEN-1:0]     wr_data_i,
  output logic                             wr_ready_o,   // also the ram write enable
  output logic [ram_arb_pkg::IDX_W-1:0]    ram_waddr_o,
  output logic [ram_arb_pkg::MASK_W-1:0]   ram_wmask_o,
  output logic [ram_arb_pkg::XLEN-1:0]     ram_wdata_o
);

  logic [ram_arb_pkg::ST_W-1:0] state;
  logic busy_stage;   // idle, mem1 or mem2
  logic take;
  logic drop;

  assign busy_stage = (state == ram_arb_pkg::ST_IDLE) ||
                      (state == ram_arb_pkg::ST_MEM1) ||
                      (state == ram_arb_pkg::ST_MEM2);

  // every stage wants the request still held
  assign take = busy_stage && wr_valid_i;
  assign drop = busy_stage && !wr_valid_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ram_arb_pkg::ST_PREIDLE;
      wr_ready_o <= 1'b0;
    end else begin
      case (state)
        ram_arb_pkg::ST_PREIDLE: begin
          state <= ram_arb_pkg::ST_IDLE;
        end
        ram_arb_pkg::ST_IDLE: begin
          wr_ready_o <= 1'b0;   // ends the ready pulse
          if (wr_valid_i) begin
            state <= ram_arb_pkg::ST_MEM1;
          end
        end
        ram_arb_pkg::ST_MEM1: begin
          wr_ready_o <= 1'b0;
          if (wr_valid_i) begin
            state <= ram_arb_pkg::ST_MEM2;
          end else begin
            state <= ram_arb_pkg::ST_IDLE;   // abandoned
          end
        end
        ram_arb_pkg::ST_MEM2: begin
          // third edge with valid held, ready for one cycle
          state      <= ram_arb_pkg::ST_IDLE;
          wr_ready_o <= wr_valid_i;
        end
        default: begin
          state      <= ram_arb_pkg::ST_IDLE;
          wr_ready_o <= 1'b0;
        end
      endcase
    end
  end

  // address, mask and data follow the held request, last capture wins
  always_ff @(posedge clk) begin
    if (take) begin
      ram_waddr_o <= wr_addr_i[3 +: ram_arb_pkg::IDX_W];   // word index
      ram_wmask_o <= wr_mask_i;
      ram_wdata_o <= wr_data_i;
    end else if (drop) begin
      ram_waddr_o <= '0;
      ram_wmask_o <= '0;
      ram_wdata_o <= '0;
    end
  end

endmodule

//--- verilog/mem_read_arb.sv
module mem_read_arb (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [ram_arb_pkg::ADDR_W-1:0]   if_addr_i,
  input  logic                             if_valid_i,
  input  logic [ram_arb_pkg::MASK_W-1:0]   if_rmask_i,
  input  logic [ram_arb_pkg::ADDR_W-1:0]   mem_addr_i,
  input  logic                             mem_valid_i,
  input  logic [ram_arb_pkg::MASK_W-1:0]   mem_rmask_i,
  input  logic [ram_arb_pkg::XLEN-1:0]     ram_rdata_i,
  output logic [ram_arb_pkg::IDX_W-1:0]    ram_raddr_o,
  output logic [ram_arb_pkg::MASK_W-1:0]   ram_rmask_o,
  output logic [ram_arb_pkg::XLEN-1:0]     if_rdata_o,
  output logic                             if_rdata_valid_o,
  output logic [ram_arb_pkg::XLEN-1:0]     mem_rdata_o,
  output logic                             mem_rdata_valid_o
);

  logic [ram_arb_pkg::ST_W-1:0] state;
  logic own_if;     // which port owns the current access
  logic own_mem;
  logic rd_strobe;  // one cycle, read word on ram_rdata_i
  logic any_req;
  logic owner_held;
  logic use_mem;
  logic load;
  logic clear;
  logic [ram_arb_pkg::IDX_W-1:0]  next_idx;
  logic [ram_arb_pkg::MASK_W-1:0] next_mask;

  assign any_req    = mem_valid_i || if_valid_i;
  assign owner_held = (own_mem && mem_valid_i) || (own_if && if_valid_i);

  always_comb begin
    // new winner in idle, mem first; otherwise the recorded owner
    if (state == ram_arb_pkg::ST_IDLE) begin
      use_mem = mem_valid_i;
    end else begin
      use_mem = own_mem;
    end
    next_idx  = use_mem ? mem_addr_i[3 +: ram_arb_pkg::IDX_W]
                        : if_addr_i[3 +: ram_arb_pkg::IDX_W];
    next_mask = use_mem ? mem_rmask_i : if_rmask_i;
    load  = ((state == ram_arb_pkg::ST_IDLE) && any_req) ||
            ((state == ram_arb_pkg::ST_MEM2) && owner_held);
    clear = (state == ram_arb_pkg::ST_IDLE) && !any_req;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ram_arb_pkg::ST_PREIDLE;
      rd_strobe <= 1'b0;
      own_if    <= 1'b0;
      own_mem   <= 1'b0;
    end else begin
      case (state)
        ram_arb_pkg::ST_PREIDLE: begin
          state <= ram_arb_pkg::ST_IDLE;
        end
        ram_arb_pkg::ST_IDLE: begin
          rd_strobe <= 1'b0;
          own_mem   <= mem_valid_i;
          own_if    <= if_valid_i && !mem_valid_i;
          if (any_req) begin
            state <= ram_arb_pkg::ST_MEM1;
          end
        end
        ram_arb_pkg::ST_MEM1: begin
          if (owner_held) begin
            state <= ram_arb_pkg::ST_MEM2;
          end else begin
            state <= ram_arb_pkg::ST_IDLE;   // owner let go
          end
        end
        ram_arb_pkg::ST_MEM2: begin
          state     <= ram_arb_pkg::ST_IDLE;
          rd_strobe <= owner_held;
        end
        default: begin
          state     <= ram_arb_pkg::ST_IDLE;
          rd_strobe <= 1'b0;
        end
      endcase
    end
  end

  // read address and mask, re-taken at the last stage
  always_ff @(posedge clk) begin
    if (load) begin
      ram_raddr_o <= next_idx;
      ram_rmask_o <= next_mask;
    end else if (clear) begin
      ram_raddr_o <= '0;
      ram_rmask_o <= '0;
    end
  end

  // route the word to the owner only
  assign mem_rdata_valid_o = rd_strobe && own_mem;
  assign if_rdata_valid_o  = rd_strobe && own_if;
  assign mem_rdata_o       = mem_rdata_valid_o ? ram_rdata_i : '0;
  assign if_rdata_o        = if_rdata_valid_o ? ram_rdata_i : '0;

endmodule

//--- verilog/ram_core.sv
module ram_core (
  input  logic                             clk,
  input  logic                             we_i,
  input  logic [ram_arb_pkg::IDX_W-1:0]    waddr_i,
  input  logic [ram_arb_pkg::MASK_W-1:0]   wmask_i,
  input  logic [ram_arb_pkg::XLEN-1:0]     wdata_i,
  input  logic [ram_arb_pkg::IDX_W-1:0]    raddr_i,
  input  logic [ram_arb_pkg::MASK_W-1:0]   rmask_i,
  output logic [ram_arb_pkg::XLEN-1:0]     rdata_o
);

  ram_arb_pkg::ram_word_u words [ram_arb_pkg::RAM_WORDS];

  ram_arb_pkg::ram_word_u wword;
  ram_arb_pkg::ram_word_u rword;
  logic [ram_arb_pkg::XLEN-1:0] lane_bits;   // rmask widened to bits

  assign wword = wdata_i;

  // masked byte write, only lanes with their bit set
  always_ff @(posedge clk) begin
    if (we_i) begin
      for (int i = 0; i < ram_arb_pkg::MASK_W; i++) begin
        if (wmask_i[i]) begin
          words[waddr_i].lanes[i] <= wword.lanes[i];
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < ram_arb_pkg::MASK_W; i++) begin
      lane_bits[8*i +: 8] = {8{rmask_i[i]}};
    end
  end

  // async read, sees the old word during a write to it
  assign rword   = words[raddr_i];
  assign rdata_o = rword.raw & lane_bits;

endmodule

//--- verilog/ram_arb.sv
module ram_arb (
  input  logic                             clk,
  input  logic                             rst,
  // if read port
  input  logic [ram_arb_pkg::ADDR_W-1:0]   if_read_addr_i,
  input  logic                             if_valid_i,
  input  logic [ram_arb_pkg::MASK_W-1:0]   if_rmask_i,
  output logic [ram_arb_pkg::XLEN-1:0]     if_rdata_o,
  output logic                             if_rdata_valid_o,
  // mem read port, wins over if
  input  logic [ram_arb_pkg::ADDR_W-1:0]   mem_read_addr_i,
  input  logic                             mem_valid_i,
  input  logic [ram_arb_pkg::MASK_W-1:0]   mem_rmask_i,
  output logic [ram_arb_pkg::XLEN-1:0]     mem_rdata_o,
  output logic                             mem_rdata_valid_o,
  // mem write port
  input  logic [ram_arb_pkg::ADDR_W-1:0]   mem_write_addr_i,
  input  logic                             mem_write_valid_i,
  input  logic [ram_arb_pkg::MASK_W-1:0]   mem_wmask_i,
  input  logic [ram_arb_pkg::XLEN-1:0]     mem_wdata_i,
  output logic                             mem_wdata_ready_o
);

  logic [ram_arb_pkg::IDX_W-1:0]  ram_waddr;
  logic [ram_arb_pkg::MASK_W-1:0] ram_wmask;
  logic [ram_arb_pkg::XLEN-1:0]   ram_wdata;
  logic [ram_arb_pkg::IDX_W-1:0]  ram_raddr;
  logic [ram_arb_pkg::MASK_W-1:0] ram_rmask;
  logic [ram_arb_pkg::XLEN-1:0]   ram_rdata;

  mem_write_fsm u_write (
    .clk         (clk),
    .rst         (rst),
    .wr_valid_i  (mem_write_valid_i),
    .wr_addr_i   (mem_write_addr_i),
    .wr_mask_i   (mem_wmask_i),
    .wr_data_i   (mem_wdata_i),
    .wr_ready_o  (mem_wdata_ready_o),   // ready pulse is the write strobe
    .ram_waddr_o (ram_waddr),
    .ram_wmask_o (ram_wmask),
    .ram_wdata_o (ram_wdata)
  );

  mem_read_arb u_read (
    .clk               (clk),
    .rst               (rst),
    .if_addr_i         (if_read_addr_i),
    .if_valid_i        (if_valid_i),
    .if_rmask_i        (if_rmask_i),
    .mem_addr_i        (mem_read_addr_i),
    .mem_valid_i       (mem_valid_i),
    .mem_rmask_i       (mem_rmask_i),
    .ram_rdata_i       (ram_rdata),
    .ram_raddr_o       (ram_raddr),
    .ram_rmask_o       (ram_rmask),
    .if_rdata_o        (if_rdata_o),
    .if_rdata_valid_o  (if_rdata_valid_o),
    .mem_rdata_o       (mem_rdata_o),
    .mem_rdata_valid_o (mem_rdata_valid_o)
  );

  ram_core u_core (
    .clk     (clk),
    .we_i    (mem_wdata_ready_o),
    .waddr_i (ram_waddr),
    .wmask_i (ram_wmask),
    .wdata_i (ram_wdata),
    .raddr_i (ram_raddr),
    .rmask_i (ram_rmask),
    .rdata_o (ram_rdata)
  );

endmodule

//--- verif/ram_arb_chk.sv
module ram_arb_chk (
  input logic clk,
  input logic rst,
  input logic if_valid_i,
  input logic mem_valid_i,
  input logic if_rdata_valid_i,
  input logic mem_rdata_valid_i,
  input logic wr_valid_i,
  input logic wr_ready_i
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;   // failed assertions so far

  // only one port gets the read word
  a_one_owner: assert property (@(posedge clk) disable iff (rst)
    !(if_rdata_valid_i && mem_rdata_valid_i))
    else begin
      fail_cnt++;
      $error("both rdata_valid outputs high");
    end

  a_if_req: assert property (@(posedge clk) disable iff (rst)
    if_rdata_valid_i |-> if_valid_i)
    else begin
      fail_cnt++;
      $error("if rdata_valid without if request");
    end

  a_mem_req: assert property (@(posedge clk) disable iff (rst)
    mem_rdata_valid_i |-> mem_valid_i)
    else begin
      fail_cnt++;
      $error("mem rdata_valid without mem request");
    end

  a_ready_pulse: assert property (@(posedge clk) disable iff (rst)
    wr_ready_i |=> !wr_ready_i)
    else begin
      fail_cnt++;
      $error("write ready high two cycles");
    end

  a_ready_req: assert property (@(posedge clk) disable iff (rst)
    wr_ready_i |-> wr_valid_i)
    else begin
      fail_cnt++;
      $error("write ready without write request");
    end

endmodule

// the top level sees the read arbiter and the write engine ports together
bind ram_arb ram_arb_chk u_chk (
  .clk               (clk),
  .rst               (rst),
  .if_valid_i        (if_valid_i),
  .mem_valid_i       (mem_valid_i),
  .if_rdata_valid_i  (if_rdata_valid_o),
  .mem_rdata_valid_i (mem_rdata_valid_o),
  .wr_valid_i        (mem_write_valid_i),
  .wr_ready_i        (mem_wdata_ready_o)
);

//--- verif/ram_arb_tb.sv
module ram_arb_tb;

  timeunit 1ns;
  timeprecision 100ps;

  logic        clk;
  logic        rst;
  logic [31:0] if_read_addr_i;
  logic        if_valid_i;
  logic [7:0]  if_rmask_i;
  logic [63:0] if_rdata_o;
  logic        if_rdata_valid_o;
  logic [31:0] mem_read_addr_i;
  logic        mem_valid_i;
  logic [7:0]  mem_rmask_i;
  logic [63:0] mem_rdata_o;
  logic        mem_rdata_valid_o;
  logic [31:0] mem_write_addr_i;
  logic        mem_write_valid_i;
  logic [7:0]  mem_wmask_i;
  logic [63:0] mem_wdata_i;
  logic        mem_wdata_ready_o;

  string       q_op[$];
  string       q_port[$];
  logic [31:0] q_addr[$];
  logic [7:0]  q_mask[$];
  logic [63:0] q_data[$];

  int cycle_cnt = 0;
  int cycle_limit = 0;

  ram_arb UUT (.*);

  always #5 clk = ~clk;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit != 0 && cycle_cnt > cycle_limit)
      stop_run("timeout, test did not finish in time");
    if (UUT.u_chk.fail_cnt != 0)
      stop_run("protocol assertion failed");
  end

  task automatic check_all_low(input string what);
    check_eq(64'(mem_wdata_ready_o), 64'd0, {what, " write ready"});
    check_eq(64'(if_rdata_valid_o), 64'd0, {what, " if rdata_valid"});
    check_eq(64'(mem_rdata_valid_o), 64'd0, {what, " mem rdata_valid"});
  endtask

  // gap so both engines are back in idle
  task automatic settle();
    repeat (2) @(posedge clk);
  endtask

  // pulse follows the third edge after the one that drives valid
  task automatic write_word(input logic [31:0] addr, input logic [7:0] mask,
                            input logic [63:0] data);
    @(posedge clk);
    mem_write_valid_i <= 1'b1;
    mem_write_addr_i  <= addr;
    mem_wmask_i       <= mask;
    mem_wdata_i       <= data;
    for (int n = 1; n <= 4; n++) begin
      @(negedge clk);
      check_eq(64'(mem_wdata_ready_o), 64'(n == 4), "write ready latency");
    end
    @(posedge clk);
    mem_write_valid_i <= 1'b0;
    @(negedge clk);
    check_eq(64'(mem_wdata_ready_o), 64'd0, "write ready pulse length");
    settle();
  endtask

  task automatic drive_read(input bit is_mem, input bit on, input logic [31:0] addr,
                            input logic [7:0] mask);
    if (is_mem) begin
      mem_valid_i     <= on;
      mem_read_addr_i <= addr;
      mem_rmask_i     <= mask;
    end else begin
      if_valid_i     <= on;
      if_read_addr_i <= addr;
      if_rmask_i     <= mask;
    end
  endtask

  task automatic read_word(input bit is_mem, input logic [31:0] addr, input logic [7:0] mask,
                           input logic [63:0] exp);
    logic own_v;
    logic oth_v;
    @(posedge clk);
    drive_read(is_mem, 1'b1, addr, mask);
    for (int n = 1; n <= 4; n++) begin
      @(negedge clk);
      own_v = is_mem ? mem_rdata_valid_o : if_rdata_valid_o;
      oth_v = is_mem ? if_rdata_valid_o : mem_rdata_valid_o;
      check_eq(64'(own_v), 64'(n == 4), "read valid latency");
      check_eq(64'(oth_v), 64'd0, "other port valid");
    end
    check_eq(is_mem ? mem_rdata_o : if_rdata_o, exp, "read data");
    check_eq(is_mem ? if_rdata_o : mem_rdata_o, 64'd0, "other port data");
    @(posedge clk);
    drive_read(is_mem, 1'b0, addr, mask);
    @(negedge clk);
    own_v = is_mem ? mem_rdata_valid_o : if_rdata_valid_o;
    check_eq(64'(own_v), 64'd0, "read valid pulse length");
    settle();
  endtask

  // mem and if launched together, if held until served
  task automatic read_both(input logic [31:0] m_addr, input logic [7:0] m_mask,
                           input logic [63:0] m_exp, input logic [31:0] i_addr,
                           input logic [7:0] i_mask, input logic [63:0] i_exp);
    bit seen;
    @(posedge clk);
    drive_read(1'b1, 1'b1, m_addr, m_mask);
    drive_read(1'b0, 1'b1, i_addr, i_mask);
    for (int n = 1; n <= 4; n++) begin
      @(negedge clk);
      check_eq(64'(mem_rdata_valid_o), 64'(n == 4), "priority mem valid latency");
      check_eq(64'(if_rdata_valid_o), 64'd0, "priority if valid during mem");
    end
    check_eq(mem_rdata_o, m_exp, "priority mem data");
    check_eq(if_rdata_o, 64'd0, "priority if data during mem");
    @(posedge clk);
    drive_read(1'b1, 1'b0, m_addr, m_mask);
    seen = 1'b0;
    for (int n = 0; n < 12 && !seen; n++) begin
      @(negedge clk);
      check_eq(64'(mem_rdata_valid_o), 64'd0, "mem valid after mem served");
      seen = if_rdata_valid_o;
    end
    if (!seen)
      stop_run("pending if read was never served");
    check_eq(if_rdata_o, i_exp, "priority if data");
    check_eq(mem_rdata_o, 64'd0, "priority mem data during if");
    @(posedge clk);
    drive_read(1'b0, 1'b0, i_addr, i_mask);
    settle();
  endtask

  // request held for one edge only
  task automatic abort_op(input bit is_write, input bit is_mem, input logic [31:0] addr,
                          input logic [7:0] mask, input logic [63:0] data);
    @(posedge clk);
    if (is_write) begin
      mem_write_valid_i <= 1'b1;
      mem_write_addr_i  <= addr;
      mem_wmask_i       <= mask;
      mem_wdata_i       <= data;
    end else begin
      drive_read(is_mem, 1'b1, addr, mask);
    end
    @(posedge clk);
    if (is_write)
      mem_write_valid_i <= 1'b0;
    else
      drive_read(is_mem, 1'b0, addr, mask);
    repeat (6) begin
      @(negedge clk);
      check_all_low("aborted access");
    end
    settle();
  endtask

  task automatic load_tests();
    int    fd;
    int    n;
    string line;
    string op;
    string port;
    logic [31:0] addr;
    logic [7:0]  mask;
    logic [63:0] data;
    fd = $fopen("verif/ram_arb_testdata.txt", "r");
    if (fd == 0)
      stop_run("cannot open verif/ram_arb_testdata.txt");
    while (!$feof(fd)) begin
      if ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %s %h %h %h", op, port, addr, mask, data);
          if (n == 5) begin
            q_op.push_back(op);
            q_port.push_back(port);
            q_addr.push_back(addr);
            q_mask.push_back(mask);
            q_data.push_back(data);
          end
        end
      end
    end
    $fclose(fd);
    if (q_op.size() == 0)
      stop_run("test data file holds no operations");
  endtask

  initial begin
    clk               = 1'b0;
    rst               = 1'b1;
    if_read_addr_i    = '0;
    if_valid_i        = 1'b0;
    if_rmask_i        = '0;
    mem_read_addr_i   = '0;
    mem_valid_i       = 1'b0;
    mem_rmask_i       = '0;
    mem_write_addr_i  = '0;
    mem_write_valid_i = 1'b0;
    mem_wmask_i       = '0;
    mem_wdata_i       = '0;

    load_tests();
    cycle_limit = q_op.size() * 12 + 50;

    repeat (4) begin
      @(negedge clk);
      check_all_low("during reset");
    end
    @(posedge clk);
    rst <= 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_all_low("after reset");
    end

    for (int i = 0; i < q_op.size(); i++) begin
      case (q_op[i])
        "W":  write_word(q_addr[i], q_mask[i], q_data[i]);
        "R":  read_word(q_port[i] == "mem", q_addr[i], q_mask[i], q_data[i]);
        "AW": abort_op(1'b1, 1'b1, q_addr[i], q_mask[i], q_data[i]);
        "AR": abort_op(1'b0, q_port[i] == "mem", q_addr[i], q_mask[i], q_data[i]);
        "RR": begin
          // mem line first, its if partner next
          if (i + 1 >= q_op.size() || q_op[i+1] != "RR")
            stop_run("RR line without its partner line");
          read_both(q_addr[i], q_mask[i], q_data[i],
                    q_addr[i+1], q_mask[i+1], q_data[i+1]);
          i++;
        end
        default: stop_run({"unknown opcode in test data: ", q_op[i]});
      endcase
    end

    if (UUT.u_chk.fail_cnt != 0) begin
      stop_run("protocol assertion failed");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

//--- verif/ram_arb_testdata.txt
# op port addr(hex) mask(hex) data(hex): write data, or expected read word
# RR lines come in pairs, mem first then if; AW and AR drop valid after one edge
W  mem 00000010 ff 1122334455667788
R  mem 00000010 ff 1122334455667788
W  mem 00000010 0f aaaaaaaabbbbbbbb
R  if  00000010 ff 11223344bbbbbbbb
W  mem 00000010 c0 ccdd000000000000
R  mem 00000010 ff ccdd3344bbbbbbbb
R  if  00000010 3c 00003344bbbb0000
W  mem 00000100 ff 0123456789abcdef
W  mem 00000108 ff fedcba9876543210
RR mem 00000100 ff 0123456789abcdef
RR if  00000108 ff fedcba9876543210
AW mem 00000100 ff deadbeefdeadbeef
R  mem 00000100 ff 0123456789abcdef
AR if  00000108 ff 0000000000000000
AR mem 00000100 ff 0000000000000000
R  if  00000108 0f 0000000076543210
W  mem 000007f8 ff 5a5a5a5a5a5a5a5a
R  mem 000007f8 ff 5a5a5a5a5a5a5a5a
R  if  000007f8 81 5a0000000000005a
W  mem 000007f8 18 0000007777000000
R  mem 000007f8 ff 5a5a5a77775a5a5a
R  if  00000010 01 00000000000000bb

//--- compile.f
verilog/ram_arb_pkg.sv
verilog/mem_write_fsm.sv
verilog/mem_read_arb.sv
verilog/ram_core.sv
verilog/ram_arb.sv
verif/ram_arb_chk.sv
verif/ram_arb_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ram_arb testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module ram_arb_tb -o ram_arb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/ram_arb_sim 2>&1)
rc=$?
echo "$out"
if [ $rc -ne 0 ]; then
  echo "simulation exited with status $rc"
fi

if echo "$out" | grep -q "Simulation PASSED"; then
  exit 0
else
  exit 1
fi
